// ==== filelist.f ====
hdl/wm_pkg.sv
hdl/apb_cmd_decoder.sv
hdl/weight_store.sv
hdl/weight_readout.sv
hdl/weight_manager_top.sv
testbench/tb_clock.sv
testbench/wm_checker.sv
testbench/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then judge the log by the fail message.
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_top \
    -f filelist.f -o tb_top_sim > sim.log 2>&1 \
    && ./obj_dir/tb_top_sim >> sim.log 2>&1 \
    || { echo "build or run failed, see sim.log"; exit 1; }
grep -q "Done: errors found" sim.log \
    && { echo "simulation failed, see sim.log"; exit 1; } \
    || echo "simulation passed"

// ==== testbench/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import wm_pkg::*;
();

    localparam int timeout_cycles = 16;

    logic     clk;
    logic     arst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    int       test_num;
    int       checks;
    int       errors;

    tb_clock #(.period_ns(100)) u_clock (.clk(clk));

    weight_manager_top #(
        .width    (16),
        .depth    (8),
        .bitwidth (8)
    ) dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    wm_checker u_checker (
        .clk      (clk),
        .arst_n   (arst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .test_num (test_num),
        .checks   (checks),
        .errors   (errors)
    );

    ////////////////////////////////////////
    // apb master
    ////////////////////////////////////////

    // starts on a falling edge, returns on the falling edge after the access.
    task automatic apb_transfer(input logic wr, input addr_t addr, input word_t wdata);
        int n;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        n = 0;
        while (!apb_rsp.pready && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!apb_rsp.pready) begin
            $display("timeout: no pready within %0d cycles at address 0x%03h",
                     timeout_cycles, addr);
            $display("Done: errors found");
            $finish;
        end else begin
            @(negedge clk);
            apb_req = '0;
        end
    endtask

    task automatic write_reg(input addr_t addr, input word_t wdata);
        apb_transfer(1'b1, addr, wdata);
    endtask

    task automatic read_reg(input addr_t addr);
        apb_transfer(1'b0, addr, '0);
    endtask

    task automatic load_weight(input int r, input int c, input word_t value);
        write_reg(reg_data, value);
        write_reg(reg_inst, {15'd0, 1'b0, 8'(r), 8'(c)});
        write_reg(reg_exec, '0);
    endtask

    task automatic step_column(input int c, input word_t codes);
        write_reg(reg_data, codes);
        write_reg(reg_inst, {15'd0, 1'b1, 8'd0, 8'(c)});
        write_reg(reg_exec, '0);
    endtask

    task automatic read_weight(input int r, input int c);
        write_reg(reg_rsel, {16'd0, 8'(r), 8'(c)});
        read_reg(reg_weight);
    endtask

    task automatic read_column(input int c);
        int r;
        for (r = 0; r < 16; r++) begin
            read_weight(r, c);
        end
    endtask

    task automatic read_all();
        int c;
        for (c = 0; c < 8; c++) begin
            read_column(c);
        end
    endtask

    initial begin
        int k;
        apb_req  = '0;
        arst_n   = 1'b0;
        test_num = 0;
        void'($urandom(68848));
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        test_num = 1;
        read_reg(reg_data);
        read_reg(reg_inst);
        read_reg(reg_rsel);
        read_all();

        test_num = 2;
        load_weight(0, 0, 32'd5);
        load_weight(3, 2, 32'hFFFF_FFF9); // -7.
        load_weight(15, 7, 32'h0000_0080);
        load_weight(9, 4, 32'd127);
        read_all();

        test_num = 3;
        load_weight(0, 2, 32'd10);
        load_weight(1, 2, 32'hFFFF_FFFD);
        step_column(2, 32'h8D8D_8D8D); // rows cycle +1, -1, 0, code 10.
        read_all();

        test_num = 4;
        write_reg(reg_data, 32'h5555_5555);
        write_reg(reg_inst, {15'd0, 1'b1, 16'h0005});
        for (k = 0; k < 130; k++) begin
            write_reg(reg_exec, '0);
        end
        read_column(5);
        write_reg(reg_data, 32'hFFFF_FFFF);
        for (k = 0; k < 260; k++) begin
            write_reg(reg_exec, '0);
        end
        read_column(5);

        test_num = 5;
        read_reg(12'h014);
        write_reg(12'h020, 32'h1234_5678);
        write_reg(reg_weight, 32'h0000_007F);
        write_reg(reg_inst, {15'd0, 1'b0, 8'd1, 8'd9}); // column out of range.
        write_reg(reg_exec, '0);
        read_all();
        write_reg(reg_data, 32'hA5C3_0F96);
        read_reg(reg_data);
        write_reg(reg_inst, 32'h0001_0A03);
        read_reg(reg_inst);
        write_reg(reg_rsel, 32'h0000_0E06);
        read_reg(reg_rsel);
        read_weight(2, 9); // selects no weight.

        test_num = 6;
        for (k = 0; k < 200; k++) begin
            case ($urandom_range(2, 0))
                0:       load_weight(int'($urandom_range(15, 0)), int'($urandom_range(7, 0)),
                                     $urandom());
                1:       step_column(int'($urandom_range(7, 0)), $urandom());
                default: read_weight(int'($urandom_range(15, 0)), int'($urandom_range(7, 0)));
            endcase
        end
        read_all();

        test_num = 7;
        repeat (2) @(negedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/wm_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module wm_checker
    import wm_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire apb_req_t apb_req,
    input  wire apb_rsp_t apb_rsp,
    input  var  int       test_num,
    output int            checks,
    output int            errors
);

    localparam int rows = 16;
    localparam int cols = 8;

    int    model [rows][cols];
    word_t data_m;
    word_t inst_m;
    word_t rsel_m;
    int    last_test;
    int    test_checks;
    int    test_errors;

    initial begin
        checks      = 0;
        errors      = 0;
        last_test   = 0;
        test_checks = 0;
        test_errors = 0;
    end

    function automatic string test_name(input int n);
        case (n)
            1: return "reset_values";
            2: return "load_readback";
            3: return "ternary_increment";
            4: return "saturation";
            5: return "error_responses";
            6: return "random_mix";
            default: return "none";
        endcase
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic void ref_apply(input word_t inst, input word_t data);
        int r;
        int c;
        int v;
        r = int'(inst[15:8]);
        c = int'(inst[7:0]);
        if (!inst[16]) begin
            model[r][c] = int'($signed(data[7:0])); // low byte, signed.
        end else begin
            for (r = 0; r < rows; r++) begin
                v = model[r][c];
                if (data[2*r +: 2] == 2'b01 && v < 127) begin
                    v = v + 1;
                end else if (data[2*r +: 2] == 2'b11 && v > -128) begin
                    v = v - 1;
                end
                model[r][c] = v;
            end
        end
    endfunction

    function automatic word_t expect_read(input addr_t addr);
        int r;
        int c;
        r = int'(rsel_m[15:8]);
        c = int'(rsel_m[7:0]);
        case (addr)
            reg_data:   return data_m;
            reg_inst:   return inst_m;
            reg_rsel:   return rsel_m;
            reg_weight: return (r < rows && c < cols) ? word_t'(model[r][c]) : '0;
            default:    return '0;
        endcase
    endfunction

    function automatic logic expect_err(input logic wr, input addr_t addr);
        logic mapped;
        logic bad_idx;
        mapped  = addr inside {reg_data, reg_inst, reg_exec, reg_rsel, reg_weight};
        bad_idx = int'(inst_m[15:8]) >= rows || int'(inst_m[7:0]) >= cols;
        return !mapped || (wr && addr == reg_weight) || (wr && addr == reg_exec && bad_idx);
    endfunction

    function automatic void compare(input string what, input word_t exp, input word_t act);
        checks++;
        test_checks++;
        if (exp !== act) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED test %s %s: expected 0x%08h actual 0x%08h",
                     test_name(test_num), what, exp, act);
        end
    endfunction

    ////////////////////////////////////////
    // bus monitor
    ////////////////////////////////////////

    always @(posedge clk) begin : monitor
        logic exp_err;
        int   r;
        int   c;
        if (!arst_n) begin
            for (r = 0; r < rows; r++) begin
                for (c = 0; c < cols; c++) begin
                    model[r][c] = 0;
                end
            end
            data_m = '0;
            inst_m = '0;
            rsel_m = '0;
        end else if (apb_req.psel && apb_req.penable) begin
            compare("pready", 32'd1, {31'd0, apb_rsp.pready}); // no wait states.
            if (apb_rsp.pready) begin
                exp_err = expect_err(apb_req.pwrite, apb_req.paddr);
                compare("pslverr", {31'd0, exp_err}, {31'd0, apb_rsp.pslverr});
                if (!apb_req.pwrite) begin
                    compare("prdata", expect_read(apb_req.paddr), apb_rsp.prdata);
                end else if (!exp_err) begin
                    case (apb_req.paddr)
                        reg_data: data_m = apb_req.pwdata;
                        reg_inst: inst_m = apb_req.pwdata & 32'h0001_ffff; // op and indices.
                        reg_rsel: rsel_m = apb_req.pwdata & 32'h0000_ffff;
                        reg_exec: ref_apply(inst_m, data_m);
                        default:  ;
                    endcase
                end
            end
        end else begin
            // pready and pslverr low outside the access phase
            compare("idle response", 32'd0, {30'd0, apb_rsp.pready, apb_rsp.pslverr});
        end
        if (test_num != last_test) begin
            if (last_test != 0) begin
                $display("test %0d %s: %0d checks, %0d errors",
                         last_test, test_name(last_test), test_checks, test_errors);
            end
            last_test   = test_num;
            test_checks = 0;
            test_errors = 0;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk; // half period per phase.
    end

endmodule

`default_nettype wire

// ==== hdl/weight_manager_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_manager_top
    import wm_pkg::*;
#(
    parameter int width    = 16,
    parameter int depth    = 8,
    parameter int bitwidth = 8
) (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire apb_req_t apb_req,
    output apb_rsp_t      apb_rsp
);

    rd_sel_t                       rd_sel;
    word_t                         data_reg;
    word_t                         inst_reg;
    word_t                         rsel_reg;
    logic                          pslverr_req;
    logic                          cmd_valid;
    wm_cmd_t                       cmd;
    logic [width*depth*bitwidth-1:0] weights_flat;

    ////////////////////////////////////////
    // input side
    ////////////////////////////////////////

    apb_cmd_decoder #(
        .width (width),
        .depth (depth)
    ) u_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .apb_req     (apb_req),
        .rd_sel      (rd_sel),
        .data_reg    (data_reg),
        .inst_reg    (inst_reg),
        .rsel_reg    (rsel_reg),
        .pslverr_req (pslverr_req),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd)
    );

    weight_store #(
        .width    (width),
        .depth    (depth),
        .bitwidth (bitwidth)
    ) u_store (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .weights_flat (weights_flat)
    );

    ////////////////////////////////////////
    // output side
    ////////////////////////////////////////

    weight_readout #(
        .width    (width),
        .depth    (depth),
        .bitwidth (bitwidth)
    ) u_readout (
        .clk          (clk),
        .arst_n       (arst_n),
        .apb_req      (apb_req),
        .rd_sel       (rd_sel),
        .data_reg     (data_reg),
        .inst_reg     (inst_reg),
        .rsel_reg     (rsel_reg),
        .pslverr_req  (pslverr_req),
        .weights_flat (weights_flat),
        .apb_rsp      (apb_rsp)
    );

endmodule

`default_nettype wire

// ==== hdl/weight_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_readout
    import wm_pkg::*;
#(
    parameter int width    = 16,
    parameter int depth    = 8,
    parameter int bitwidth = 8
) (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire apb_req_t                          apb_req,
    input  wire rd_sel_t                           rd_sel,
    input  wire word_t                             data_reg,
    input  wire word_t                             inst_reg,
    input  wire word_t                             rsel_reg,
    input  wire logic                              pslverr_req,
    input  wire logic [width*depth*bitwidth-1:0]   weights_flat,
    output apb_rsp_t                               apb_rsp
);

    logic                setup;
    idx_t                sel_row;
    idx_t                sel_col;
    logic                sel_ok;
    logic [bitwidth-1:0] sel_weight;
    word_t               weight_word;
    word_t               rdata;
    apb_rsp_t            rsp_q;

    assign setup = apb_req.psel && !apb_req.penable;

    ////////////////////////////////////////
    // weight select
    ////////////////////////////////////////

    assign sel_row = rsel_reg[15:8];
    assign sel_col = rsel_reg[7:0];
    assign sel_ok  = (int'(sel_row) < width) && (int'(sel_col) < depth);

    always_comb begin
        sel_weight = '0; // out of range reads zero.
        if (sel_ok) begin
            sel_weight = weights_flat[(int'(sel_row)*depth + int'(sel_col))*bitwidth +: bitwidth];
        end
    end

    assign weight_word = {{(32-bitwidth){sel_weight[bitwidth-1]}}, sel_weight};

    always_comb begin
        case (rd_sel)
            rd_data:   rdata = data_reg;
            rd_inst:   rdata = inst_reg;
            rd_rsel:   rdata = rsel_reg;
            rd_weight: rdata = weight_word;
            default:   rdata = '0;
        endcase
    end

    ////////////////////////////////////////
    // response register
    ////////////////////////////////////////

    // loaded at the end of setup, so valid for the whole access cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_q <= '0;
        end else if (setup) begin
            rsp_q.prdata  <= rdata;
            rsp_q.pready  <= 1'b1;
            rsp_q.pslverr <= pslverr_req;
        end else begin
            rsp_q.pready  <= 1'b0; // prdata holds.
            rsp_q.pslverr <= 1'b0;
        end
    end

    assign apb_rsp = rsp_q;

endmodule

`default_nettype wire

// ==== hdl/weight_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_store
    import wm_pkg::*;
#(
    parameter int width    = 16,
    parameter int depth    = 8,
    parameter int bitwidth = 8
) (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire logic                              cmd_valid,
    input  wire wm_cmd_t                           cmd,
    output logic [width*depth*bitwidth-1:0]        weights_flat
);

    localparam int w_bits = (width > 1) ? $clog2(width) : 1;
    localparam int d_bits = (depth > 1) ? $clog2(depth) : 1;

    typedef logic signed [bitwidth-1:0] weight_t;

    localparam weight_t w_max = {1'b0, {(bitwidth-1){1'b1}}};
    localparam weight_t w_min = {1'b1, {(bitwidth-1){1'b0}}};

    weight_t weights [width][depth];
    weight_t inc_col [width];

    logic [w_bits-1:0] row;
    logic [d_bits-1:0] col;

    assign row = cmd.w_idx[w_bits-1:0];
    assign col = cmd.d_idx[d_bits-1:0];

    // 01 steps up, 11 steps down, anything else holds.
    function automatic weight_t sat_step(input weight_t w, input logic [1:0] code);
        weight_t res;
        res = w;
        if (code == 2'b01 && w != w_max) begin
            res = w + weight_t'(1);
        end else if (code == 2'b11 && w != w_min) begin
            res = w - weight_t'(1);
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // increment datapath
    ////////////////////////////////////////

    // one two-bit step per row, so width is at most 16.
    for (genvar r = 0; r < width; r++) begin : g_inc
        assign inc_col[r] = sat_step(weights[r][col], cmd.data[2*r +: 2]);
    end

    ////////////////////////////////////////
    // weight array
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < width; r++) begin
                for (int d = 0; d < depth; d++) begin
                    weights[r][d] <= '0;
                end
            end
        end else if (cmd_valid) begin
            if (cmd.op == op_load) begin
                weights[row][col] <= cmd.data[bitwidth-1:0];
            end else begin
                for (int r = 0; r < width; r++) begin
                    weights[r][col] <= inc_col[r]; // whole column at once.
                end
            end
        end
    end

    // row major, row 0 column 0 in the low bits
    for (genvar r = 0; r < width; r++) begin : g_row
        for (genvar d = 0; d < depth; d++) begin : g_col
            assign weights_flat[(r*depth+d)*bitwidth +: bitwidth] = weights[r][d];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/apb_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_cmd_decoder
    import wm_pkg::*;
#(
    parameter int width = 16,
    parameter int depth = 8
) (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire apb_req_t apb_req,
    output rd_sel_t       rd_sel,
    output word_t         data_reg,
    output word_t         inst_reg,
    output word_t         rsel_reg,
    output logic          pslverr_req,
    output logic          cmd_valid,
    output wm_cmd_t       cmd
);

    localparam word_t inst_mask = 32'h0001_ffff; // op plus two index fields.
    localparam word_t rsel_mask = 32'h0000_ffff;

    logic setup;
    logic access_wr;
    logic addr_ok;
    logic exec_wr;
    logic weight_wr;
    logic idx_ok;
    idx_t inst_w;
    idx_t inst_d;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    assign setup     = apb_req.psel && !apb_req.penable;
    assign access_wr = apb_req.psel && apb_req.penable && apb_req.pwrite;

    assign exec_wr   = apb_req.pwrite && (apb_req.paddr == reg_exec);
    assign weight_wr = apb_req.pwrite && (apb_req.paddr == reg_weight);

    assign inst_w = inst_reg[15:8];
    assign inst_d = inst_reg[7:0];
    assign idx_ok = (int'(inst_w) < width) && (int'(inst_d) < depth);

    always_comb begin
        rd_sel  = rd_none;
        addr_ok = 1'b1;
        case (apb_req.paddr)
            reg_data:   rd_sel = rd_data;
            reg_inst:   rd_sel = rd_inst;
            reg_exec:   rd_sel = rd_none; // reads back as zero.
            reg_rsel:   rd_sel = rd_rsel;
            reg_weight: rd_sel = rd_weight;
            default:    addr_ok = 1'b0;
        endcase
        if (apb_req.pwrite) begin
            rd_sel = rd_none;
        end
    end

    // held for the whole transfer, sampled by the readout at setup
    assign pslverr_req = apb_req.psel &&
                         (!addr_ok || weight_wr || (exec_wr && !idx_ok));

    ////////////////////////////////////////
    // writable registers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_reg <= '0;
            inst_reg <= '0;
            rsel_reg <= '0;
        end else if (access_wr) begin
            case (apb_req.paddr)
                reg_data: data_reg <= apb_req.pwdata;
                reg_inst: inst_reg <= apb_req.pwdata & inst_mask;
                reg_rsel: rsel_reg <= apb_req.pwdata & rsel_mask;
                default:  ;
            endcase
        end
    end

    ////////////////////////////////////////
    // command issue
    ////////////////////////////////////////

    // valid through the access cycle, applied on the edge that ends it.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= setup && exec_wr && idx_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (setup && exec_wr) begin
            cmd.op    <= wm_op_t'(inst_reg[16]);
            cmd.w_idx <= inst_w;
            cmd.d_idx <= inst_d;
            cmd.data  <= data_reg;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/wm_pkg.sv ====
`default_nettype none

package wm_pkg;

    ////////////////////////////////////////
    // bus and index types
    ////////////////////////////////////////

    typedef logic [31:0] word_t; // apb data word.
    typedef logic [11:0] addr_t; // apb byte address.
    typedef logic [7:0]  idx_t;  // row or column index field.

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    ////////////////////////////////////////
    // commands
    ////////////////////////////////////////

    typedef enum logic [0:0] {
        op_load      = 1'b0,
        op_increment = 1'b1
    } wm_op_t;

    typedef struct packed {
        wm_op_t op;
        idx_t   w_idx;
        idx_t   d_idx;
        word_t  data;
    } wm_cmd_t;

    // readback source for the current transfer
    typedef enum logic [2:0] {
        rd_none   = 3'd0,
        rd_data   = 3'd1,
        rd_inst   = 3'd2,
        rd_rsel   = 3'd3,
        rd_weight = 3'd4
    } rd_sel_t;

    // register map
    localparam addr_t reg_data   = 12'h000;
    localparam addr_t reg_inst   = 12'h004; // [16] op, [15:8] w_idx, [7:0] d_idx.
    localparam addr_t reg_exec   = 12'h008; // write only.
    localparam addr_t reg_rsel   = 12'h00C; // [15:8] row, [7:0] column.
    localparam addr_t reg_weight = 12'h010; // read only.

endpackage

`default_nettype wire
